// File: source/therm_pkg.sv
// shared constants and types for the thermometer
// bus timing, read spacing, fahrenheit conversion constants,
// digit divisors, sensor reading type, controller state encoding
`default_nettype none

package therm_pkg;

  // two-wire bus timing
  localparam int scl_half = 4;                // sys_clk cycles per half scl period
  localparam logic [7:0] lm75_addr_rd = 8'h91; // addr 1001_000 + read bit

  // controller spacing
  localparam int read_gap   = 64;                  // idle cycles between reads
  localparam int read_limit = 2 * scl_half * 40;   // give up on a read after this

  // fahrenheit: f = ((c * 230) >> 7) + 32
  localparam logic [7:0] k_fahren = 8'd230;   // 9/5 scaled by 128
  localparam logic [7:0] f_offset = 8'd32;

  // digit extraction divisors
  localparam logic [7:0] div_hund = 8'd100;
  localparam logic [7:0] div_ten  = 8'd10;
  localparam logic [7:0] div_one  = 8'd1;

  typedef logic [8:0] temp_t;   // [8:1] whole degrees, [0] half degree

  typedef enum logic [2:0] {
    st_wait,      // gap before next read
    st_read,      // sensor read in flight
    st_mul,       // fahrenheit multiply
    st_div_hund,  // divide by 100
    st_div_ten,   // divide by 10
    st_div_one,   // divide by 1
    st_frac       // celsius half-degree digit
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/div_if.sv
// divider request/result bundle
// ctrl side issues start with operands, div side returns quo, rem, done
`timescale 1ns/1ps
`default_nettype none

interface div_if;

  logic       start;     // one-cycle request pulse
  logic [7:0] dividend;  // held until done
  logic [7:0] divisor;   // never zero
  logic [7:0] quo;       // valid from done to next start
  logic [7:0] rem;
  logic       done;      // one-cycle pulse, 9 cycles after start

  // requester side
  modport ctrl (output start, dividend, divisor,
                input  quo, rem, done);

  // divider side
  modport div (input  start, dividend, divisor,
               output quo, rem, done);

endinterface

`default_nettype wire

// File: source/lm75_reader.sv
// two-wire bus master for one lm75 temperature read per request
// start, address byte, ack check, two data bytes, stop
// open-drain data line as sda_in plus sda_oe
`timescale 1ns/1ps
`default_nettype none

module lm75_reader (
  input  logic             sys_clk,
  input  logic             sys_rst_l,
  input  logic             read_temp,
  input  logic             iic_sda_in,
  output logic             iic_scl,
  output logic             iic_sda_oe,
  output therm_pkg::temp_t temp,
  output logic             temp_ready
);
  import therm_pkg::*;

  typedef enum logic [2:0] {r_idle, r_start, r_addr, r_rd0, r_rd1, r_stop} rd_state_t;

  rd_state_t                   state;
  logic [$clog2(scl_half)-1:0] hcnt;      // cycle within half period
  logic                        phase;     // 0 = scl low half, 1 = scl high half
  logic [3:0]                  bit_cnt;   // 8 bits + ack slot
  logic                        got_data;  // both bytes received
  logic [15:0]                 rx_sr;     // received data bytes
  logic                        half_end;
  logic                        sda_drive; // 1 = pull line low

  assign half_end = (int'(hcnt) == scl_half - 1);

  // what the master puts on the line during the scl low half
  always_comb begin
    case (state)
      r_addr:  sda_drive = (bit_cnt == 4'd8) ? 1'b0 : ~lm75_addr_rd[~bit_cnt[2:0]];
      r_rd0:   sda_drive = (bit_cnt == 4'd8);  // ack first byte
      r_stop:  sda_drive = 1'b1;               // low before stop edge
      default: sda_drive = 1'b0;               // released, nack on 2nd byte
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state      <= r_idle;
      hcnt       <= '0;
      phase      <= 1'b0;
      bit_cnt    <= '0;
      got_data   <= 1'b0;
      iic_scl    <= 1'b1;
      iic_sda_oe <= 1'b0;
      temp_ready <= 1'b0;
    end else begin
      temp_ready <= 1'b0;
      if (state == r_idle) begin
        hcnt <= '0;
        if (read_temp) begin       // busy reads are simply not seen here
          iic_sda_oe <= 1'b1;      // start: sda falls while scl high
          got_data   <= 1'b0;
          state      <= r_start;
        end
      end else begin
        hcnt <= half_end ? '0 : hcnt + 1'b1;
        // data changes one cycle into the low half
        if (!phase && int'(hcnt) == 1 && state != r_start)
          iic_sda_oe <= sda_drive;
        if (half_end) begin
          if (state == r_start) begin
            iic_scl <= 1'b0;
            phase   <= 1'b0;
            bit_cnt <= '0;
            state   <= r_addr;
          end else if (!phase) begin
            iic_scl <= 1'b1;       // rising scl, slave samples
            phase   <= 1'b1;
          end else if (state == r_stop) begin
            iic_sda_oe <= 1'b0;    // stop: sda rises while scl high
            temp_ready <= got_data;
            phase      <= 1'b0;
            state      <= r_idle;
          end else begin
            iic_scl <= 1'b0;
            phase   <= 1'b0;
            bit_cnt <= (bit_cnt == 4'd8) ? '0 : bit_cnt + 1'b1;
            if (bit_cnt == 4'd8) begin
              case (state)
                r_addr:  state <= iic_sda_in ? r_stop : r_rd0;  // nack aborts
                r_rd0:   state <= r_rd1;
                default: begin
                  got_data <= 1'b1;
                  state    <= r_stop;
                end
              endcase
            end
          end
        end
      end
    end
  end

  // data path, sampled at end of scl high half
  always_ff @(posedge sys_clk) begin
    if (half_end && phase && bit_cnt != 4'd8 && (state == r_rd0 || state == r_rd1))
      rx_sr <= {rx_sr[14:0], iic_sda_in};
    if (half_end && phase && state == r_stop && got_data)
      temp <= rx_sr[15:7];   // msb byte + top bit of lsb byte
  end

endmodule

`default_nettype wire

// File: source/udiv8.sv
// serial restoring 8-bit unsigned divider
// one quotient bit per cycle, done 9 cycles after start
`timescale 1ns/1ps
`default_nettype none

module udiv8 (
  input  logic sys_clk,
  input  logic sys_rst_l,
  div_if.div   bus
);

  logic       busy;
  logic [2:0] cnt;     // step index
  logic [7:0] acc;     // partial remainder
  logic [7:0] q_sr;    // dividend shifting out, quotient shifting in
  logic [8:0] part;    // remainder with next dividend bit
  logic [9:0] diff;    // trial subtraction, [9] = borrow
  logic [7:0] acc_nx;
  logic [7:0] q_nx;

  always_comb begin
    part   = {acc, q_sr[7]};
    diff   = {1'b0, part} - {2'b00, bus.divisor};
    acc_nx = diff[9] ? part[7:0] : diff[7:0];  // restore on borrow
    q_nx   = {q_sr[6:0], ~diff[9]};
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      busy     <= 1'b0;
      cnt      <= '0;
      bus.done <= 1'b0;
    end else begin
      bus.done <= busy && cnt == 3'd7;
      if (bus.start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == 3'd7)
          busy <= 1'b0;   // last bit this cycle
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus.start) begin
      acc  <= '0;
      q_sr <= bus.dividend;
    end else if (busy) begin
      acc  <= acc_nx;
      q_sr <= q_nx;
    end
    if (busy && cnt == 3'd7) begin
      bus.quo <= q_nx;
      bus.rem <= acc_nx;
    end
  end

endmodule

`default_nettype wire

// File: source/umul8.sv
// serial shift-add multiplier, mul_a times the fahrenheit constant
// one multiplier bit per cycle, mul_done 9 cycles after mul_start
`timescale 1ns/1ps
`default_nettype none

module umul8 (
  input  logic        sys_clk,
  input  logic        sys_rst_l,
  input  logic        mul_start,
  input  logic [7:0]  mul_a,
  output logic [15:0] mul_p,
  output logic        mul_done
);
  import therm_pkg::*;

  logic        busy;
  logic [2:0]  cnt;
  logic [15:0] acc;     // {partial sum, multiplier bits left}
  logic [8:0]  sum;     // upper half plus addend, with carry
  logic [15:0] acc_nx;

  always_comb begin
    sum    = {1'b0, acc[15:8]} + (acc[0] ? {1'b0, k_fahren} : 9'd0);
    acc_nx = {sum, acc[7:1]};   // shift right one
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      busy     <= 1'b0;
      cnt      <= '0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= busy && cnt == 3'd7;
      if (mul_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == 3'd7)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mul_start)
      acc <= {8'h00, mul_a};
    else if (busy)
      acc <= acc_nx;
    if (busy && cnt == 3'd7)
      mul_p <= acc_nx;   // full product
  end

endmodule

`default_nettype wire

// File: source/therm_ctrl.sv
// thermometer sequencer
// read spacing, optional fahrenheit multiply, three divisions,
// digit latch strobes and unit indicators
`timescale 1ns/1ps
`default_nettype none

module therm_ctrl (
  input  logic             sys_clk,
  input  logic             sys_rst_l,
  input  logic             fahren,
  output logic             read_temp,
  input  therm_pkg::temp_t temp,
  input  logic             temp_ready,
  output logic             mul_start,
  output logic [7:0]       mul_a,
  input  logic [15:0]      mul_p,
  input  logic             mul_done,
  div_if.ctrl              div,
  output logic             disp_latch_one,
  output logic             disp_latch_ten,
  output logic             disp_latch_hund,
  output logic [3:0]       disp_data,
  output logic             dp_l,
  output logic             sel_f,
  output logic             sel_c
);
  import therm_pkg::*;

  ctrl_state_t                   state, state_nx;
  logic [$clog2(read_limit)-1:0] tmr, tmr_nx;  // gap and read timeout
  logic                          fahren_q;     // unit held for the sequence
  logic                          rd_go, mul_go, div_go;
  logic [7:0]                    div_num, div_den;
  logic [2:0]                    latch_sel;    // {hund, ten, one}
  logic [3:0]                    show_data;

  assign mul_a = temp[8:1];   // whole degrees
  assign dp_l  = fahren_q;    // point lit in celsius
  assign sel_f = ~fahren_q;
  assign sel_c = fahren_q;

  always_comb begin
    state_nx  = state;
    tmr_nx    = '0;
    rd_go     = 1'b0;
    mul_go    = 1'b0;
    div_go    = 1'b0;
    div_num   = div.rem;      // next digit works on the remainder
    div_den   = div_ten;
    latch_sel = 3'b000;
    show_data = div.quo[3:0];
    case (state)
      st_wait: begin
        tmr_nx = tmr + 1'b1;
        if (int'(tmr) == read_gap - 1) begin
          tmr_nx   = '0;
          rd_go    = 1'b1;
          state_nx = st_read;
        end
      end
      st_read: begin
        tmr_nx = tmr + 1'b1;
        if (temp_ready) begin
          tmr_nx = '0;
          if (fahren) begin
            mul_go   = 1'b1;
            state_nx = st_mul;
          end else begin
            div_go   = 1'b1;
            div_num  = temp[8:1];
            div_den  = div_hund;
            state_nx = st_div_hund;
          end
        end else if (int'(tmr) == read_limit - 1) begin
          tmr_nx   = '0;        // nacked read, try again after the gap
          state_nx = st_wait;
        end
      end
      st_mul: if (mul_done) begin
        div_go   = 1'b1;
        div_num  = mul_p[14:7] + f_offset;  // >>7 then +32
        div_den  = div_hund;
        state_nx = st_div_hund;
      end
      st_div_hund: if (div.done) begin
        latch_sel = {fahren_q, 2'b00};  // celsius drops hundreds
        div_go    = 1'b1;
        state_nx  = st_div_ten;
      end
      st_div_ten: if (div.done) begin
        latch_sel = fahren_q ? 3'b010 : 3'b100;
        div_go    = 1'b1;
        div_den   = div_one;
        state_nx  = st_div_one;
      end
      st_div_one: if (div.done) begin
        latch_sel = fahren_q ? 3'b001 : 3'b010;
        state_nx  = fahren_q ? st_wait : st_frac;
      end
      default: begin            // st_frac
        latch_sel = 3'b001;
        show_data = temp[0] ? 4'd5 : 4'd0;
        state_nx  = st_wait;
      end
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state           <= st_wait;
      tmr             <= '0;
      fahren_q        <= 1'b0;
      read_temp       <= 1'b0;
      mul_start       <= 1'b0;
      div.start       <= 1'b0;
      disp_latch_hund <= 1'b1;
      disp_latch_ten  <= 1'b1;
      disp_latch_one  <= 1'b1;
    end else begin
      state           <= state_nx;
      tmr             <= tmr_nx;
      read_temp       <= rd_go;
      mul_start       <= mul_go;
      div.start       <= div_go;
      disp_latch_hund <= ~latch_sel[2];  // one-cycle low strobes
      disp_latch_ten  <= ~latch_sel[1];
      disp_latch_one  <= ~latch_sel[0];
      if (state == st_read && temp_ready)
        fahren_q <= fahren;
    end
  end

  // operands and display data
  always_ff @(posedge sys_clk) begin
    if (div_go) begin
      div.dividend <= div_num;
      div.divisor  <= div_den;
    end
    if (|latch_sel)
      disp_data <= show_data;
  end

endmodule

`default_nettype wire

// File: source/therm_top.sv
// thermometer top level
// sensor reader, sequencer, divider and multiplier on plain pins
`timescale 1ns/1ps
`default_nettype none

module therm_top (
  input  logic       sys_clk,
  input  logic       sys_rst_l,
  output logic       iic_scl,
  input  logic       iic_sda_in,
  output logic       iic_sda_oe,     // high = pull sda low
  input  logic       fahren,
  output logic       disp_latch_one,
  output logic       disp_latch_ten,
  output logic       disp_latch_hund,
  output logic [3:0] disp_data,
  output logic       dp_l,
  output logic       sel_f,
  output logic       sel_c
);
  import therm_pkg::*;

  logic        read_temp;
  temp_t       temp;
  logic        temp_ready;
  logic        mul_start;
  logic [7:0]  mul_a;
  logic [15:0] mul_p;
  logic        mul_done;

  div_if u_div_bus ();   // ctrl <-> divider

  lm75_reader u_reader (
    .sys_clk, .sys_rst_l, .read_temp, .iic_sda_in,
    .iic_scl, .iic_sda_oe, .temp, .temp_ready
  );

  udiv8 u_div (.sys_clk, .sys_rst_l, .bus(u_div_bus.div));

  umul8 u_mul (.sys_clk, .sys_rst_l, .mul_start, .mul_a, .mul_p, .mul_done);

  therm_ctrl u_ctrl (
    .sys_clk, .sys_rst_l, .fahren, .read_temp, .temp, .temp_ready,
    .mul_start, .mul_a, .mul_p, .mul_done, .div(u_div_bus.ctrl),
    .disp_latch_one, .disp_latch_ten, .disp_latch_hund, .disp_data,
    .dp_l, .sel_f, .sel_c
  );

endmodule

`default_nettype wire

// File: sim/therm_asserts.sv
// concurrent checks on latch strobes, scl high time and reset levels
`timescale 1ns/1ps
`default_nettype none

module therm_asserts (
  input logic                   sys_clk,
  input logic                   sys_rst_l,
  input logic                   disp_latch_one,
  input logic                   disp_latch_ten,
  input logic                   disp_latch_hund,
  input logic                   iic_scl,
  input logic                   iic_sda_oe,
  input therm_pkg::ctrl_state_t state
);
  import therm_pkg::*;

  hund_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    !disp_latch_hund |=> disp_latch_hund) else $error("hundreds latch held low");
  ten_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    !disp_latch_ten |=> disp_latch_ten) else $error("tens latch held low");
  one_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    !disp_latch_one |=> disp_latch_one) else $error("ones latch held low");
  single_latch: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    $countones({~disp_latch_one, ~disp_latch_ten, ~disp_latch_hund}) <= 1)
    else $error("two latches low together");
  ones_from_end: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    !disp_latch_one |-> $past(state) inside {st_div_one, st_frac})
    else $error("ones latch outside the last step");
  scl_high_time: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    $rose(iic_scl) |-> iic_scl [*scl_half]) else $error("scl high half too short");
  sda_idle_rst: assert property (@(posedge sys_clk)
    !sys_rst_l |-> !iic_sda_oe) else $error("sda driven in reset");

endmodule

bind therm_top therm_asserts u_asserts (
  .sys_clk, .sys_rst_l, .disp_latch_one, .disp_latch_ten, .disp_latch_hund,
  .iic_scl, .iic_sda_oe, .state(u_ctrl.state)
);

`default_nettype wire

// File: sim/tb_therm.sv
// thermometer testbench
// clock, reset, lm75 sensor model, stimulus table, display checks
`timescale 1ns/1ps
`default_nettype none

module tb_therm;
  localparam int n_rows   = 10;
  localparam int tmo      = 3000;    // cycles allowed per wait
  localparam logic [7:0] addr_rd = 8'h91;

  logic       sys_clk = 1'b0;
  logic       sys_rst_l = 1'b0;
  logic       iic_sda_in = 1'b1;
  logic       fahren = 1'b0;
  logic       iic_scl, iic_sda_oe;
  logic       disp_latch_one, disp_latch_ten, disp_latch_hund;
  logic [3:0] disp_data;
  logic       dp_l, sel_f, sel_c;

  // stimulus table: degrees, half bit, fahrenheit, withhold ack
  logic [7:0] tbl_deg  [n_rows];
  logic       tbl_half [n_rows];
  logic       tbl_f    [n_rows];
  logic       tbl_nack [n_rows];

  int errors = 0;
  int checks = 0;

  // sensor model state
  logic [7:0] cur_deg = 8'd0;
  logic       cur_half = 1'b0, cur_nack = 1'b0;
  logic       drv = 1'b0, prev_scl = 1'b1, prev_line = 1'b1;
  logic       in_frame = 1'b0, first_fall = 1'b0, active = 1'b0;
  logic [3:0] bitpos = '0;
  logic [1:0] byte_idx = '0;
  logic [7:0] sr = '0;
  int         start_cnt = 0;
  wire        line = ~(iic_sda_oe | drv);   // open-drain wired and

  // latch monitor state
  int         hund_cnt = 0, ten_cnt = 0, one_cnt = 0, seq_pos = 0;
  logic [3:0] cap_hund, cap_ten, cap_one;

  therm_top u_therm_top (
    .sys_clk, .sys_rst_l, .iic_scl, .iic_sda_in, .iic_sda_oe, .fahren,
    .disp_latch_one, .disp_latch_ten, .disp_latch_hund, .disp_data,
    .dp_l, .sel_f, .sel_c
  );

  always #50 sys_clk = ~sys_clk;

  // lm75 model, decodes bus on sys_clk samples
  always @(posedge sys_clk) begin : sensor_model
    logic       drv_nx;
    logic [3:0] nb_pos;
    logic [1:0] nb_byte;
    logic [7:0] sent;
    drv_nx = drv;
    if (!sys_rst_l) begin
      drv_nx   = 1'b0;
      in_frame <= 1'b0;
    end else if (iic_scl && prev_scl && prev_line && !line) begin  // start
      if (in_frame) begin
        errors = errors + 1;
        $display("bus error at %0t: start condition without a stop", $time);
      end
      in_frame   <= 1'b1;
      first_fall <= 1'b1;
      bitpos     <= '0;
      byte_idx   <= '0;
      active     <= 1'b0;
      start_cnt  <= start_cnt + 1;
    end else if (iic_scl && prev_scl && !prev_line && line) begin  // stop
      in_frame <= 1'b0;
    end else if (iic_scl && !prev_scl && in_frame) begin   // scl rise
      if (bitpos < 4'd8) begin
        sr <= {sr[6:0], line};
        if (byte_idx == 2'd0 && bitpos == 4'd7) begin
          checks = checks + 1;
          if ({sr[6:0], line} != addr_rd) begin
            errors = errors + 1;
            $display("mismatch at %0t: address byte %h", $time, {sr[6:0], line});
          end
          active <= ({sr[6:0], line} == addr_rd) && !cur_nack;
        end
      end else if (active && byte_idx != 2'd0) begin
        checks = checks + 1;
        if (byte_idx == 2'd1 && line) begin
          errors = errors + 1;
          $display("mismatch at %0t: no master ack on first byte", $time);
        end
        if (byte_idx == 2'd2 && !line) begin
          errors = errors + 1;
          $display("mismatch at %0t: master acked second byte", $time);
        end
      end
    end else if (!iic_scl && prev_scl && in_frame) begin   // scl fall
      if (first_fall) begin
        first_fall <= 1'b0;
      end else begin
        nb_pos  = (bitpos == 4'd8) ? 4'd0 : bitpos + 4'd1;
        nb_byte = (bitpos == 4'd8) ? byte_idx + 2'd1 : byte_idx;
        sent    = (nb_byte == 2'd1) ? cur_deg : {cur_half, 7'b0};
        if (nb_byte == 2'd0 && nb_pos == 4'd8)
          drv_nx = active;                      // address ack
        else if (active && (nb_byte == 2'd1 || nb_byte == 2'd2) && nb_pos < 4'd8)
          drv_nx = ~sent[7 - int'(nb_pos)];
        else
          drv_nx = 1'b0;
        bitpos   <= nb_pos;
        byte_idx <= nb_byte;
      end
    end
    drv        <= drv_nx;
    prev_scl   <= iic_scl;
    prev_line  <= line;
    iic_sda_in <= ~(iic_sda_oe | drv_nx);
  end

  // latch capture and strobe order
  always @(posedge sys_clk) begin
    if (sys_rst_l) begin
      if (!disp_latch_hund) begin
        cap_hund <= disp_data;
        hund_cnt <= hund_cnt + 1;
        if (seq_pos != 0) begin
          errors = errors + 1;
          $display("hundreds latch strobed out of order at %0t", $time);
        end
        seq_pos <= 1;
      end
      if (!disp_latch_ten) begin
        cap_ten <= disp_data;
        ten_cnt <= ten_cnt + 1;
        if (seq_pos != 1) begin
          errors = errors + 1;
          $display("tens latch strobed out of order at %0t", $time);
        end
        seq_pos <= 2;
      end
      if (!disp_latch_one) begin
        cap_one <= disp_data;
        one_cnt <= one_cnt + 1;
        if (seq_pos != 2) begin
          errors = errors + 1;
          $display("ones latch strobed out of order at %0t", $time);
        end
        seq_pos <= 0;
      end
    end
  end

  // digits from the display rules, {hund, ten, one}
  function automatic logic [11:0] expect_digits(input int deg, input int half, input int f);
    int v;
    if (f != 0) begin
      v = ((deg * 230) >> 7) + 32;
      return {4'(v / 100), 4'((v / 10) % 10), 4'(v % 10)};
    end
    return {4'((deg / 10) % 10), 4'(deg % 10), (half != 0) ? 4'd5 : 4'd0};
  endfunction

  task automatic wait_for_start(input int from, output bit ok);
    int n;
    n = 0;
    while (start_cnt == from && n < tmo) begin
      @(posedge sys_clk);
      n++;
    end
    ok = (start_cnt != from);
    if (!ok) begin
      errors = errors + 1;
      $display("timeout waiting for a bus start condition at %0t", $time);
    end
  endtask

  task automatic wait_for_ones(input int from, output bit ok);
    int n;
    n = 0;
    while (one_cnt == from && n < tmo) begin
      @(posedge sys_clk);
      n++;
    end
    ok = (one_cnt != from);
    if (!ok) begin
      errors = errors + 1;
      $display("timeout waiting for the ones latch strobe at %0t", $time);
    end
  endtask

  initial begin
    int         r, sh, st, so, s_base;
    bit         ok, started;
    logic [11:0] exp_d;
    tbl_deg = '{8'd25, 8'd0, 8'd99, 8'd37, 8'd120, 8'd0, 8'd60, 8'd73, 8'd100, 8'd9};
    tbl_half = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    tbl_f    = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    tbl_nack = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    ok      = 1'b1;
    started = 1'b0;

    for (r = 0; r < 8; r++) begin   // reset held, levels idle
      @(posedge sys_clk);
      if (r > 0) begin              // first edge applies the reset
        checks = checks + 1;
        if (!disp_latch_hund || !disp_latch_ten || !disp_latch_one || iic_sda_oe) begin
          errors = errors + 1;
          $display("mismatch at %0t: outputs not idle during reset", $time);
        end
      end
    end
    sys_rst_l <= 1'b1;
    repeat (2) @(posedge sys_clk);
    checks = checks + 1;
    if (!disp_latch_hund || !disp_latch_ten || !disp_latch_one || iic_sda_oe) begin
      errors = errors + 1;
      $display("mismatch at %0t: outputs not idle after reset", $time);
    end

    for (r = 0; r < n_rows && ok; r++) begin
      s_base = start_cnt;
      @(posedge sys_clk);
      fahren   <= tbl_f[r];
      cur_deg  <= tbl_deg[r];
      cur_half <= tbl_half[r];
      cur_nack <= tbl_nack[r];
      sh = hund_cnt;
      st = ten_cnt;
      so = one_cnt;
      if (!started)
        wait_for_start(s_base, ok);
      if (ok && tbl_nack[r]) begin
        wait_for_start(start_cnt, ok);   // retry read after the gap
        checks = checks + 1;
        if (ok && (hund_cnt != sh || ten_cnt != st || one_cnt != so)) begin
          errors = errors + 1;
          $display("mismatch at %0t: latch strobed after a missing ack", $time);
        end
        started = 1'b1;
      end else if (ok) begin
        wait_for_ones(so, ok);
        started = 1'b0;
        if (ok) begin
          @(posedge sys_clk);
          exp_d  = expect_digits(tbl_deg[r], tbl_half[r], tbl_f[r]);
          checks = checks + 1;
          if ({cap_hund, cap_ten, cap_one} != exp_d) begin
            errors = errors + 1;
            $display("mismatch at %0t: row %0d digits %h%h%h, expected %h", $time, r,
                     cap_hund, cap_ten, cap_one, exp_d);
          end
          if (hund_cnt != sh + 1 || ten_cnt != st + 1 || one_cnt != so + 1) begin
            errors = errors + 1;
            $display("mismatch at %0t: row %0d latch strobe counts", $time, r);
          end
          if (dp_l != tbl_f[r] || sel_f != !tbl_f[r] || sel_c != tbl_f[r]) begin
            errors = errors + 1;
            $display("mismatch at %0t: row %0d unit indicators", $time, r);
          end
        end
      end
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
source/therm_pkg.sv
source/div_if.sv
source/lm75_reader.sv
source/udiv8.sv
source/umul8.sv
source/therm_ctrl.sv
source/therm_top.sv
sim/therm_asserts.sv
sim/tb_therm.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_therm \
		-Mdir obj_dir -o sim_therm

run: compile
	@out=$$(./obj_dir/sim_therm); echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
